/* design/shared_fifo_macros.svh */
`ifndef SHARED_FIFO_MACROS_SVH
`define SHARED_FIFO_MACROS_SVH

`default_nettype none

// number of logical FIFOs sharing the array
`define SF_NUM_FIFOS 2

// entries in the shared flop array
`define SF_DEPTH 8

// payload bits per entry
`define SF_WIDTH 8

`default_nettype wire

`endif

/* design/shared_fifo_cfg_pkg.sv */
`include "shared_fifo_macros.svh"

`default_nettype none

package shared_fifo_cfg_pkg;

  localparam int fifo_id_width = (`SF_NUM_FIFOS > 1) ? $clog2(`SF_NUM_FIFOS) : 1;
  localparam int addr_width = (`SF_DEPTH > 1) ? $clog2(`SF_DEPTH) : 1;
  localparam int count_width = $clog2(`SF_DEPTH + 1);

  typedef logic [fifo_id_width-1:0] fifo_id_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [count_width-1:0] count_t;

  // base and bound are both inclusive
  typedef struct packed {
    addr_t base;
    addr_t bound;
  } partition_t;

  typedef partition_t [`SF_NUM_FIFOS-1:0] partition_cfg_t;

  // pointer step with wrap from bound back to base
  function automatic addr_t next_addr(addr_t ptr, partition_t part);
    return (ptr == part.bound) ? part.base : addr_t'(ptr + 1'b1);
  endfunction

endpackage

`default_nettype wire

/* design/shared_fifo_data_pkg.sv */
`include "shared_fifo_macros.svh"

`default_nettype none

package shared_fifo_data_pkg;

  typedef logic [`SF_WIDTH-1:0] data_t;

  // one beat on the push side, no ready
  typedef struct packed {
    shared_fifo_cfg_pkg::fifo_id_t fifo_id;
    data_t data;
  } push_beat_t;

  // single write port into the flop array
  typedef struct packed {
    logic en;
    shared_fifo_cfg_pkg::addr_t addr;
    data_t data;
  } storage_wr_t;

endpackage

`default_nettype wire

/* design/push_credit_ingress.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module push_credit_ingress (
  input  logic                               clk,
  input  logic                               rst,
  input  shared_fifo_cfg_pkg::partition_cfg_t config_partition,
  input  logic                               push_valid,
  input  shared_fifo_data_pkg::push_beat_t   push_beat,
  input  logic [`SF_NUM_FIFOS-1:0]           popped,
  output logic                               ing_valid,
  output shared_fifo_data_pkg::push_beat_t   ing_beat,
  output logic                               push_overflow,
  output logic                               config_error,
  output logic                               push_receiver_in_reset
);

  shared_fifo_cfg_pkg::count_t [`SF_NUM_FIFOS-1:0] free_slots;
  logic [`SF_NUM_FIFOS-1:0] take;
  logic push_has_slot;
  logic config_bad;

  assign push_has_slot = free_slots[push_beat.fifo_id] != '0;

  always_comb begin
    for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
      take[i] = push_valid && push_has_slot &&
                (push_beat.fifo_id == shared_fifo_cfg_pkg::fifo_id_t'(i));
    end
  end

  // inverted range, out of array, or overlap between any two partitions
  always_comb begin
    config_bad = 1'b0;
    for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
      if (config_partition[i].bound < config_partition[i].base) config_bad = 1'b1;
      if (int'(config_partition[i].bound) >= `SF_DEPTH) config_bad = 1'b1;
      for (int j = i + 1; j < `SF_NUM_FIFOS; j++) begin
        if ((config_partition[i].base <= config_partition[j].bound) &&
            (config_partition[j].base <= config_partition[i].bound)) begin
          config_bad = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        free_slots[i] <= shared_fifo_cfg_pkg::count_t'(config_partition[i].bound) -
                         shared_fifo_cfg_pkg::count_t'(config_partition[i].base) +
                         shared_fifo_cfg_pkg::count_t'(1);
      end
      ing_valid              <= 1'b0;
      push_overflow          <= 1'b0;
      config_error           <= 1'b0;
      push_receiver_in_reset <= 1'b1;
    end else begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        free_slots[i] <= free_slots[i] - shared_fifo_cfg_pkg::count_t'(take[i]) +
                         shared_fifo_cfg_pkg::count_t'(popped[i]);
      end
      ing_valid              <= push_valid && push_has_slot;
      push_overflow          <= push_overflow | (push_valid & ~push_has_slot); // sticky
      config_error           <= config_bad;
      push_receiver_in_reset <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    ing_beat <= push_beat; // qualified by ing_valid
  end

endmodule

`default_nettype wire

/* design/partition_write_ctrl.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module partition_write_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  shared_fifo_cfg_pkg::partition_cfg_t config_partition,
  input  logic                                ing_valid,
  input  shared_fifo_data_pkg::push_beat_t    ing_beat,
  output shared_fifo_data_pkg::storage_wr_t   wr,
  output logic [`SF_NUM_FIFOS-1:0]            committed
);

  shared_fifo_cfg_pkg::addr_t [`SF_NUM_FIFOS-1:0] tail;
  logic [`SF_NUM_FIFOS-1:0] hit;

  logic wr_en_q;
  shared_fifo_cfg_pkg::addr_t wr_addr_q;
  shared_fifo_data_pkg::data_t wr_data_q;

  // one-hot select of the FIFO this beat goes to
  always_comb begin
    for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
      hit[i] = ing_valid && (ing_beat.fifo_id == shared_fifo_cfg_pkg::fifo_id_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        tail[i] <= config_partition[i].base;
      end
      wr_en_q   <= 1'b0;
      committed <= '0;
    end else begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        if (hit[i]) begin
          tail[i] <= shared_fifo_cfg_pkg::next_addr(tail[i], config_partition[i]);
        end
      end
      wr_en_q   <= ing_valid;
      committed <= hit; // one-cycle pulse
    end
  end

  // address and data only matter with wr_en_q
  always_ff @(posedge clk) begin
    wr_addr_q <= tail[ing_beat.fifo_id];
    wr_data_q <= ing_beat.data;
  end

  always_comb begin
    wr.en   = wr_en_q;
    wr.addr = wr_addr_q;
    wr.data = wr_data_q;
  end

endmodule

`default_nettype wire

/* design/flop_storage.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module flop_storage (
  input  logic                                            clk,
  input  logic                                            rst,
  input  shared_fifo_data_pkg::storage_wr_t               wr,
  input  shared_fifo_cfg_pkg::addr_t  [`SF_NUM_FIFOS-1:0] rd_addr,
  output shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] rd_data
);

  shared_fifo_data_pkg::data_t mem [`SF_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SF_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // one combinational read port per FIFO head
  always_comb begin
    for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
      rd_data[i] = mem[rd_addr[i]];
    end
  end

endmodule

`default_nettype wire

/* design/partition_read_ctrl.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module partition_read_ctrl (
  input  logic                                            clk,
  input  logic                                            rst,
  input  shared_fifo_cfg_pkg::partition_cfg_t             config_partition,
  input  logic [`SF_NUM_FIFOS-1:0]                        committed,
  output shared_fifo_cfg_pkg::addr_t  [`SF_NUM_FIFOS-1:0] rd_addr,
  input  shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] rd_data,
  output logic [`SF_NUM_FIFOS-1:0]                        pop_valid,
  input  logic [`SF_NUM_FIFOS-1:0]                        pop_ready,
  output shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] pop_data,
  output logic [`SF_NUM_FIFOS-1:0]                        popped,
  output logic [`SF_NUM_FIFOS-1:0]                        push_credit
);

  shared_fifo_cfg_pkg::addr_t  [`SF_NUM_FIFOS-1:0] head;
  shared_fifo_cfg_pkg::count_t [`SF_NUM_FIFOS-1:0] occupancy;

  always_comb begin
    for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
      pop_valid[i] = occupancy[i] != '0;
    end
  end

  assign popped = pop_valid & pop_ready;

  // head entry is presented straight from the array
  assign rd_addr  = head;
  assign pop_data = rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        head[i]      <= config_partition[i].base;
        occupancy[i] <= '0;
      end
      push_credit <= '0;
    end else begin
      for (int i = 0; i < `SF_NUM_FIFOS; i++) begin
        // commit and pop on the same edge cancel out
        occupancy[i] <= occupancy[i] + shared_fifo_cfg_pkg::count_t'(committed[i]) -
                        shared_fifo_cfg_pkg::count_t'(popped[i]);
        if (popped[i]) begin
          head[i] <= shared_fifo_cfg_pkg::next_addr(head[i], config_partition[i]);
        end
      end
      push_credit <= popped; // one credit per popped beat
    end
  end

endmodule

`default_nettype wire

/* design/shared_fifo_push_credit.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module shared_fifo_push_credit (
  input  logic                                            clk,
  input  logic                                            rst,
  input  shared_fifo_cfg_pkg::partition_cfg_t             config_partition,
  output logic                                            config_error,
  input  logic                                            push_valid,
  input  shared_fifo_data_pkg::push_beat_t                push_beat,
  output logic [`SF_NUM_FIFOS-1:0]                        push_credit,
  output logic                                            push_receiver_in_reset,
  output logic                                            push_overflow,
  output logic [`SF_NUM_FIFOS-1:0]                        pop_valid,
  input  logic [`SF_NUM_FIFOS-1:0]                        pop_ready,
  output shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] pop_data
);

  logic ing_valid;
  shared_fifo_data_pkg::push_beat_t ing_beat;
  shared_fifo_data_pkg::storage_wr_t wr;
  logic [`SF_NUM_FIFOS-1:0] committed;
  logic [`SF_NUM_FIFOS-1:0] popped;
  shared_fifo_cfg_pkg::addr_t  [`SF_NUM_FIFOS-1:0] rd_addr;
  shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] rd_data;

  push_credit_ingress u_ingress (
    .clk,
    .rst,
    .config_partition,
    .push_valid,
    .push_beat,
    .popped,
    .ing_valid,
    .ing_beat,
    .push_overflow,
    .config_error,
    .push_receiver_in_reset
  );

  partition_write_ctrl u_write_ctrl (
    .clk,
    .rst,
    .config_partition,
    .ing_valid,
    .ing_beat,
    .wr,
    .committed
  );

  flop_storage u_storage (
    .clk,
    .rst,
    .wr,
    .rd_addr,
    .rd_data
  );

  partition_read_ctrl u_read_ctrl (
    .clk,
    .rst,
    .config_partition,
    .committed,
    .rd_addr,
    .rd_data,
    .pop_valid,
    .pop_ready,
    .pop_data,
    .popped,
    .push_credit
  );

endmodule

`default_nettype wire

/* testbench/shared_fifo_push_credit_assertions.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module shared_fifo_push_credit_assertions (
  input logic                                            clk,
  input logic                                            rst,
  input logic [`SF_NUM_FIFOS-1:0]                        push_credit,
  input logic [`SF_NUM_FIFOS-1:0]                        pop_valid,
  input logic [`SF_NUM_FIFOS-1:0]                        pop_ready,
  input shared_fifo_data_pkg::data_t [`SF_NUM_FIFOS-1:0] pop_data,
  input logic                                            push_overflow
);

  int unsigned failures = 0;

  // second reset cycle on, the credit register is already cleared
  a_no_credit_in_reset: assert property (@(posedge clk) rst ##1 rst |-> push_credit == '0)
    else begin $error("push_credit high during reset"); failures++; end

  a_pop_valid_cleared: assert property (@(posedge clk) rst |=> pop_valid == '0)
    else begin $error("pop_valid still high after a reset cycle"); failures++; end

  a_overflow_sticky: assert property (@(posedge clk) !rst && push_overflow |=> push_overflow)
    else begin $error("push_overflow fell outside reset"); failures++; end

  for (genvar i = 0; i < `SF_NUM_FIFOS; i++) begin : g_fifo
    a_pop_data_held: assert property (@(posedge clk) disable iff (rst)
      pop_valid[i] && !pop_ready[i] |=> pop_valid[i] && $stable(pop_data[i]))
      else begin $error("pop port %0d changed while stalled", i); failures++; end
  end

endmodule

bind shared_fifo_push_credit shared_fifo_push_credit_assertions u_assertions (
  .clk, .rst, .push_credit, .pop_valid, .pop_ready, .pop_data, .push_overflow
);

`default_nettype wire

/* testbench/shared_fifo_push_credit_tb.sv */
`include "shared_fifo_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module shared_fifo_push_credit_tb;

  localparam int num_fifos = `SF_NUM_FIFOS;
  localparam int order_beats = 16; // per FIFO
  localparam int credit_beats = 4; // per FIFO
  localparam int isolation_beats = 11;
  localparam int wrap_beats = 24; // per FIFO
  localparam int total_beats =
    num_fifos * (order_beats + credit_beats + wrap_beats) + isolation_beats;
  localparam int watchdog_cycles = 6 * 200 + 20 * total_beats;

  logic clk;
  logic rst;
  shared_fifo_cfg_pkg::partition_cfg_t config_partition;
  logic config_error;
  logic push_valid;
  shared_fifo_data_pkg::push_beat_t push_beat;
  logic [num_fifos-1:0] push_credit;
  logic push_receiver_in_reset;
  logic push_overflow;
  logic [num_fifos-1:0] pop_valid;
  logic [num_fifos-1:0] pop_ready;
  shared_fifo_data_pkg::data_t [num_fifos-1:0] pop_data;

  shared_fifo_data_pkg::data_t expected_q [num_fifos][$];
  int credits [num_fifos]; // sender-side credit model
  int pop_count [num_fifos];
  int credit_count [num_fifos];
  logic [num_fifos-1:0] popped_q;

  shared_fifo_push_credit u_shared_fifo_push_credit (
    .clk, .rst, .config_partition, .config_error, .push_valid, .push_beat, .push_credit,
    .push_receiver_in_reset, .push_overflow, .pop_valid, .pop_ready, .pop_data
  );

  always #5 clk = ~clk;

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_data(input shared_fifo_data_pkg::data_t got, exp, input string what);
    if (got !== exp)
      stop_on_failure($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic compare_flag(input logic got, exp, input string what);
    if (got !== exp)
      stop_on_failure($sformatf("Error at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  function automatic int part_size(shared_fifo_cfg_pkg::partition_t p);
    return int'(p.bound) - int'(p.base) + 1; // both ends inclusive
  endfunction

  function automatic shared_fifo_cfg_pkg::partition_t make_partition(int base, int bound);
    shared_fifo_cfg_pkg::partition_t p;
    p.base  = shared_fifo_cfg_pkg::addr_t'(base);
    p.bound = shared_fifo_cfg_pkg::addr_t'(bound);
    return p;
  endfunction

  task automatic set_even_split();
    for (int i = 0; i < num_fifos; i++) begin
      config_partition[i] = make_partition(i * `SF_DEPTH / num_fifos,
                                           (i + 1) * `SF_DEPTH / num_fifos - 1);
    end
  endtask

  // scoreboard, credit model and credit pulse check
  always @(posedge clk) begin
    if (rst) begin
      popped_q = '0;
    end else begin
      for (int i = 0; i < num_fifos; i++) begin
        compare_flag(push_credit[i], popped_q[i], $sformatf("push_credit[%0d]", i));
        if (push_credit[i]) begin
          credits[i]++;
          credit_count[i]++;
        end
        if (pop_valid[i] && pop_ready[i]) begin
          if (expected_q[i].size() == 0)
            stop_on_failure($sformatf("FIFO %0d popped a beat that was never accepted", i));
          else
            compare_data(pop_data[i], expected_q[i].pop_front(), $sformatf("pop_data[%0d]", i));
          pop_count[i]++;
        end
        popped_q[i] = pop_valid[i] & pop_ready[i];
      end
    end
  end

  task automatic push_one(input int f, input shared_fifo_data_pkg::data_t d);
    int waited;
    waited = 0;
    while (credits[f] == 0) begin
      @(posedge clk); #1;
      waited++;
      if (waited > 100) stop_on_failure($sformatf("no credit came back for FIFO %0d", f));
    end
    push_valid = 1'b1;
    push_beat.fifo_id = shared_fifo_cfg_pkg::fifo_id_t'(f);
    push_beat.data = d;
    expected_q[f].push_back(d);
    credits[f]--;
    @(posedge clk); #1;
    push_valid = 1'b0;
  endtask

  task automatic wait_drained(input int f);
    int waited;
    waited = 0;
    while (expected_q[f].size() != 0) begin
      @(posedge clk); #1;
      waited++;
      if (waited > 500) stop_on_failure($sformatf("FIFO %0d did not drain", f));
    end
    repeat (2) @(posedge clk); // last credit pulse
    #1;
  endtask

  task automatic check_credits_home();
    for (int i = 0; i < num_fifos; i++) begin
      compare_flag(credits[i] == part_size(config_partition[i]), 1'b1, "credit count");
      compare_flag(credit_count[i] == pop_count[i], 1'b1, "credit pulses per pop");
    end
  endtask

  task automatic test_reset_state();
    rst = 1'b1;
    repeat (4) begin
      @(posedge clk); #1;
      compare_flag(push_receiver_in_reset, 1'b1, "push_receiver_in_reset in reset");
      compare_flag(push_overflow, 1'b0, "push_overflow in reset");
      compare_flag(config_error, 1'b0, "config_error in reset");
      for (int i = 0; i < num_fifos; i++) begin
        compare_flag(pop_valid[i], 1'b0, "pop_valid in reset");
        compare_flag(push_credit[i], 1'b0, "push_credit in reset");
      end
    end
    rst = 1'b0;
    for (int i = 0; i < num_fifos; i++) begin
      credits[i] = part_size(config_partition[i]); // initial credits owned by the sender
      pop_count[i] = 0;
      credit_count[i] = 0;
    end
    @(posedge clk); #1;
    compare_flag(push_receiver_in_reset, 1'b0, "push_receiver_in_reset after reset");
    compare_flag(config_error, 1'b0, "config_error with even split");
    compare_flag(push_overflow, 1'b0, "push_overflow after reset");
  endtask

  task automatic test_order();
    pop_ready = '1;
    for (int k = 0; k < order_beats; k++) begin
      for (int f = 0; f < num_fifos; f++) begin
        push_one(f, shared_fifo_data_pkg::data_t'($urandom));
      end
    end
    for (int f = 0; f < num_fifos; f++) wait_drained(f);
  endtask

  task automatic test_credit_return();
    pop_ready = '0; // use up all credits first
    for (int k = 0; k < credit_beats; k++) begin
      for (int f = 0; f < num_fifos; f++) begin
        push_one(f, shared_fifo_data_pkg::data_t'($urandom));
      end
    end
    repeat (3) @(posedge clk);
    #1;
    // every partition exactly full, still no overflow
    for (int f = 0; f < num_fifos; f++) begin
      compare_flag(pop_valid[f], 1'b1, "pop_valid with full FIFO");
    end
    compare_flag(push_overflow, 1'b0, "push_overflow with full FIFOs");
    pop_ready = '1;
    for (int f = 0; f < num_fifos; f++) wait_drained(f);
    check_credits_home();
  endtask

  task automatic test_isolation();
    pop_ready = '1;
    pop_ready[0] = 1'b0;
    for (int k = 0; k < 4; k++) begin
      push_one(0, shared_fifo_data_pkg::data_t'($urandom));
      push_one(1, shared_fifo_data_pkg::data_t'($urandom));
    end
    push_one(1, shared_fifo_data_pkg::data_t'($urandom));
    push_one(1, shared_fifo_data_pkg::data_t'($urandom));
    wait_drained(1);
    compare_flag(pop_valid[0], 1'b1, "stalled FIFO 0 pop_valid");
    compare_data(pop_data[0], expected_q[0][0], "stalled FIFO 0 head");
    compare_flag(push_overflow, 1'b0, "push_overflow before the extra push");
    // sender error, FIFO 0 has no credit left
    push_valid = 1'b1;
    push_beat.fifo_id = shared_fifo_cfg_pkg::fifo_id_t'(0);
    push_beat.data = 8'hee;
    @(posedge clk); #1;
    push_valid = 1'b0;
    @(posedge clk); #1;
    compare_flag(push_overflow, 1'b1, "push_overflow after push without credit");
    pop_ready[0] = 1'b1;
    wait_drained(0);
    check_credits_home();
  endtask

  task automatic expect_config_error(input logic exp, input string what);
    repeat (2) @(posedge clk);
    #1;
    compare_flag(config_error, exp, what);
  endtask

  task automatic test_config_check();
    config_partition[0] = make_partition(0, 4);
    config_partition[1] = make_partition(4, 7);
    expect_config_error(1'b1, "config_error on overlap");
    config_partition[0] = make_partition(3, 1);
    expect_config_error(1'b1, "config_error on bound below base");
    set_even_split();
    // only representable when the depth is not a power of two
    if (`SF_DEPTH < (1 << shared_fifo_cfg_pkg::addr_width)) begin
      config_partition[1] = make_partition(`SF_DEPTH / 2, `SF_DEPTH);
      expect_config_error(1'b1, "config_error on bound past the array");
      set_even_split();
    end
    expect_config_error(1'b0, "config_error after restoring the even split");
  endtask

  task automatic test_wrap();
    logic done;
    done = 1'b0;
    fork
      begin
        for (int k = 0; k < wrap_beats; k++) begin
          for (int f = 0; f < num_fifos; f++) begin
            push_one(f, shared_fifo_data_pkg::data_t'($urandom));
          end
        end
        for (int f = 0; f < num_fifos; f++) wait_drained(f);
        done = 1'b1;
      end
      begin
        while (!done) begin
          @(posedge clk); #1;
          for (int f = 0; f < num_fifos; f++) pop_ready[f] = ($urandom % 3) != 0;
        end
      end
    join
    pop_ready = '1;
    wait_drained(0);
    check_credits_home();
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_on_failure($sformatf("timeout, tests still running after %0d cycles", watchdog_cycles));
  end

  initial begin
    void'($urandom(32'h34c9));
    clk = 1'b0;
    rst = 1'b1;
    push_valid = 1'b0;
    push_beat = '0;
    pop_ready = '1;
    set_even_split();
    test_reset_state();
    test_order();
    test_credit_return();
    test_isolation();
    test_config_check();
    test_wrap();
    if (u_shared_fifo_push_credit.u_assertions.failures == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_on_failure("concurrent assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

/* shared_fifo_push_credit.f */
+incdir+design
design/shared_fifo_cfg_pkg.sv
design/shared_fifo_data_pkg.sv
design/push_credit_ingress.sv
design/partition_write_ctrl.sv
design/flop_storage.sv
design/partition_read_ctrl.sv
design/shared_fifo_push_credit.sv
testbench/shared_fifo_push_credit_assertions.sv
testbench/shared_fifo_push_credit_tb.sv

/* Bender.yml */
package:
  name: shared_fifo_push_credit

export_include_dirs:
  - design

sources:
  - files:
      - design/shared_fifo_cfg_pkg.sv
      - design/shared_fifo_data_pkg.sv
      - design/push_credit_ingress.sv
      - design/partition_write_ctrl.sv
      - design/flop_storage.sv
      - design/partition_read_ctrl.sv
      - design/shared_fifo_push_credit.sv
  - target: test
    files:
      - testbench/shared_fifo_push_credit_assertions.sv
      - testbench/shared_fifo_push_credit_tb.sv
